//--- vlog.f
common/uart_reg_pkg.sv
common/uart_line_pkg.sv
src/byte_fifo.sv
src/uart_regs.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
src/uart_top.sv
testbench/uart_sva.sv
testbench/tb_uart.sv

//--- testbench/tb_uart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart;

    localparam int FIFO_DEPTH = 8;
    localparam int CLOCK_HZ   = 50_000_000;
    localparam int BAUD_DIV   = 11;      // Twelve clocks per bit keeps frames short.
    localparam int POLL_LIMIT = 20000;
    localparam logic [31:0] ERR_MASK = (32'h1 << uart_reg_pkg::ST_FRAME_ERR) |
                                       (32'h1 << uart_reg_pkg::ST_OVERRUN) |
                                       (32'h1 << uart_reg_pkg::ST_PARITY_ERR);

    logic                    clk;
    logic                    rst_n;
    uart_reg_pkg::bus_req_t  bus_req;
    uart_reg_pkg::reg_data_t rdata;
    logic                    tx;
    logic                    rx;
    logic                    irq;
    logic                    use_model;
    logic                    model_rx;
    logic                    irq_at_read;

    int         errors;
    int         tests_run;
    int         tests_failed;
    int         test_start_errors;
    integer     seed;
    logic [7:0] exp_q [$];   // Bytes the receive FIFO should deliver, oldest first.

    assign rx = use_model ? model_rx : tx;

    uart_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CLOCK_HZ   (CLOCK_HZ)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .rdata   (rdata),
        .tx      (tx),
        .rx      (rx),
        .irq     (irq)
    );

    always #4 clk = ~clk;

    // ****************************************
    // Bus and serial helpers
    // ****************************************
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_write(input uart_reg_pkg::reg_addr_t addr, input logic [31:0] data);
        bus_req.write = 1'b1;
        bus_req.addr  = addr;
        bus_req.wdata = data;
        next_cycle();
        bus_req.write = 1'b0;
        bus_req.wdata = '0;
    endtask

    task automatic bus_read(input uart_reg_pkg::reg_addr_t addr, output logic [31:0] data);
        bus_req.read = 1'b1;
        bus_req.addr = addr;
        #2;
        data        = rdata;   // Mid-cycle, well clear of both edges.
        irq_at_read = irq;
        next_cycle();
        bus_req.read = 1'b0;
    endtask

    task automatic wait_bit(input uart_reg_pkg::reg_addr_t addr, input int pos,
                            input logic value, input string what);
        logic [31:0] data;
        int          polls;
        polls = 0;
        bus_read(addr, data);
        while (data[pos] !== value && polls < POLL_LIMIT) begin
            bus_read(addr, data);
            polls++;
        end
        if (data[pos] !== value) begin
            $display("Timeout while waiting for %s", what);
            errors++;
        end
    endtask

    // Reads the receive FIFO until it is empty and matches each byte to the model.
    task automatic collect_rx();
        logic [31:0] status;
        logic [31:0] data;
        int          n;
        n = 0;
        bus_read(uart_reg_pkg::ADDR_STATUS, status);
        while (status[uart_reg_pkg::ST_RX_AVAIL] && n < 2 * FIFO_DEPTH) begin
            bus_read(uart_reg_pkg::ADDR_DATA, data);
            if (exp_q.size() == 0) begin
                $display("Received byte 0x%02h that was never sent", data[7:0]);
                errors++;
            end else begin
                check("rx data", data, {24'h0, exp_q.pop_front()});
            end
            n++;
            bus_read(uart_reg_pkg::ADDR_STATUS, status);
        end
        if (exp_q.size() != 0) begin
            $display("%0d sent bytes never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    function automatic logic expected_parity(input logic [7:0] data, input logic odd);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++)
            ones += data[i];
        return logic'(ones % 2) ^ odd;   // Even parity evens out the count of ones.
    endfunction

    task automatic drive_bit(input logic value);
        model_rx = value;
        repeat (BAUD_DIV + 1) next_cycle();
    endtask

    task automatic send_frame(input logic [7:0] data, input logic odd, input logic flip);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(data[i]);
        drive_bit(expected_parity(data, odd) ^ flip);
        drive_bit(1'b1);
    endtask

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - test_start_errors);
        end
    endtask

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin
        logic [31:0] data;
        logic [7:0]  byte_val;
        logic [3:0]  ctrl;
        logic [2:0]  en;
        clk          = 1'b0;
        rst_n        = 1'b0;
        bus_req      = '0;
        use_model    = 1'b0;
        model_rx     = 1'b1;
        irq_at_read  = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'h706c;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test();
        bus_read(uart_reg_pkg::ADDR_CTRL, data);
        check("CTRL", data, 32'h1);
        bus_read(uart_reg_pkg::ADDR_BAUD, data);
        check("BAUD", data, CLOCK_HZ / 115200 - 1);
        bus_read(uart_reg_pkg::ADDR_IRQ_STATUS, data);
        check("IRQ_STATUS", data, 32'h0);
        bus_read(uart_reg_pkg::ADDR_STATUS, data);
        check("STATUS", data, 32'h1 << uart_reg_pkg::ST_TX_NOT_FULL);
        check("irq", irq_at_read, 32'h0);
        finish_test("reset values");

        bus_write(uart_reg_pkg::ADDR_BAUD, BAUD_DIV);

        start_test();
        for (int i = 0; i < 20; i++) begin
            ctrl     = 4'($random(seed));
            ctrl[0]  = 1'b1;
            byte_val = 8'($random(seed));
            bus_write(uart_reg_pkg::ADDR_CTRL, ctrl);
            bus_write(uart_reg_pkg::ADDR_DATA, byte_val);
            exp_q.push_back(byte_val);
            wait_bit(uart_reg_pkg::ADDR_IRQ_STATUS, uart_reg_pkg::IRQ_TX_DONE, 1'b1,
                     "the end of a loopback frame");
            collect_rx();
            bus_read(uart_reg_pkg::ADDR_STATUS, data);
            check("STATUS error bits", data & ERR_MASK, 32'h0);
        end
        finish_test("loopback");

        start_test();
        ctrl = 4'b0011;
        ctrl[uart_reg_pkg::CTRL_PARITY_ODD] = 1'($random(seed));
        byte_val = 8'($random(seed));
        bus_write(uart_reg_pkg::ADDR_CTRL, ctrl);
        use_model = 1'b1;
        send_frame(byte_val, ctrl[uart_reg_pkg::CTRL_PARITY_ODD], 1'b1);
        wait_bit(uart_reg_pkg::ADDR_IRQ_STATUS, uart_reg_pkg::IRQ_ERR, 1'b1,
                 "the error interrupt");
        bus_read(uart_reg_pkg::ADDR_STATUS, data);
        check("STATUS", data & (ERR_MASK | 32'h1), 32'h1 << uart_reg_pkg::ST_PARITY_ERR);
        bus_write(uart_reg_pkg::ADDR_IRQ_STATUS, 32'h1 << uart_reg_pkg::IRQ_ERR);
        bus_read(uart_reg_pkg::ADDR_STATUS, data);
        check("ST_PARITY_ERR", data[uart_reg_pkg::ST_PARITY_ERR], 32'h0);
        bus_read(uart_reg_pkg::ADDR_IRQ_STATUS, data);
        check("IRQ_ERR", data[uart_reg_pkg::IRQ_ERR], 32'h0);
        use_model = 1'b0;
        finish_test("parity error");

        start_test();
        bus_write(uart_reg_pkg::ADDR_CTRL, 32'h1);
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            byte_val = 8'($random(seed));
            bus_write(uart_reg_pkg::ADDR_DATA, byte_val);
            if (i < FIFO_DEPTH)
                exp_q.push_back(byte_val);   // The last byte finds the FIFO full.
        end
        wait_bit(uart_reg_pkg::ADDR_IRQ_STATUS, uart_reg_pkg::IRQ_TX_DONE, 1'b1,
                 "the transmit FIFO to drain");
        bus_read(uart_reg_pkg::ADDR_STATUS, data);
        check("ST_OVERRUN", data[uart_reg_pkg::ST_OVERRUN], 32'h1);
        collect_rx();
        bus_write(uart_reg_pkg::ADDR_IRQ_STATUS, 32'h1 << uart_reg_pkg::IRQ_ERR);
        finish_test("overrun");

        start_test();
        bus_write(uart_reg_pkg::ADDR_CTRL, 32'h0);
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            byte_val = 8'($random(seed));
            bus_write(uart_reg_pkg::ADDR_DATA, byte_val);
            if (i < FIFO_DEPTH)
                exp_q.push_back(byte_val);
        end
        bus_read(uart_reg_pkg::ADDR_STATUS, data);
        check("ST_TX_NOT_FULL", data[uart_reg_pkg::ST_TX_NOT_FULL], 32'h0);
        bus_write(uart_reg_pkg::ADDR_CTRL, 32'h1);
        wait_bit(uart_reg_pkg::ADDR_IRQ_STATUS, uart_reg_pkg::IRQ_TX_DONE, 1'b1,
                 "the transmit FIFO to drain");
        collect_rx();
        finish_test("transmit back-pressure");

        start_test();
        byte_val = 8'($random(seed));
        bus_write(uart_reg_pkg::ADDR_DATA, byte_val);
        exp_q.push_back(byte_val);
        bus_read(uart_reg_pkg::ADDR_IRQ_STATUS, data);
        check("IRQ_TX_DONE", data[uart_reg_pkg::IRQ_TX_DONE], 32'h0);
        wait_bit(uart_reg_pkg::ADDR_IRQ_STATUS, uart_reg_pkg::IRQ_TX_DONE, 1'b1,
                 "the transmit done interrupt");
        for (int i = 0; i < 6; i++) begin
            en = 3'($random(seed));
            bus_write(uart_reg_pkg::ADDR_IRQ_EN, en);
            bus_read(uart_reg_pkg::ADDR_IRQ_STATUS, data);
            check("IRQ_STATUS", data, 32'b011);
            check("irq", irq_at_read, |(en & 3'b011));
        end
        collect_rx();
        for (int i = 0; i < 6; i++) begin
            en = 3'($random(seed));
            bus_write(uart_reg_pkg::ADDR_IRQ_EN, en);
            bus_read(uart_reg_pkg::ADDR_IRQ_STATUS, data);
            check("IRQ_STATUS", data, 32'b010);
            check("irq", irq_at_read, |(en & 3'b010));
        end
        finish_test("interrupt mask");

        if (i_dut.i_sva.fail_count != 0) begin
            $display("%0d assertion failures during the run", i_dut.i_sva.fail_count);
            errors += i_dut.i_sva.fail_count;
        end
        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/uart_sva.sv
`timescale 1ns/1ps
`default_nettype none

module uart_sva #(
    parameter int FIFO_DEPTH = 8
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic tx,
    input wire logic tx_busy,
    input wire logic tx_done,
    input wire logic rx_valid,
    input wire logic tx_push,
    input wire logic tx_pop,
    input wire logic rx_push,
    input wire logic rx_pop
);

    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    int                 fail_count = 0;
    logic [LEVEL_W-1:0] tx_level;   // Bytes held in each FIFO, counted from its push and pop.
    logic [LEVEL_W-1:0] rx_level;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_level <= '0;
            rx_level <= '0;
        end else begin
            case ({tx_push, tx_pop})
                2'b10:   tx_level <= tx_level + 1'b1;
                2'b01:   tx_level <= tx_level - 1'b1;
                default: ;
            endcase
            case ({rx_push, rx_pop})
                2'b10:   rx_level <= rx_level + 1'b1;
                2'b01:   rx_level <= rx_level - 1'b1;
                default: ;
            endcase
        end
    end

    // The line rests high between frames.
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
        else begin
            fail_count++;
            $error("tx is low while the transmitter is idle");
        end

    rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid)
        else begin
            fail_count++;
            $error("rx valid lasted more than one cycle");
        end

    tx_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) tx_done |=> !tx_done)
        else begin
            fail_count++;
            $error("tx done lasted more than one cycle");
        end

    tx_push_room: assert property (@(posedge clk) disable iff (!rst_n)
                                   tx_push |-> tx_level < FIFO_DEPTH)
        else begin
            fail_count++;
            $error("push into a full transmit FIFO");
        end

    rx_push_room: assert property (@(posedge clk) disable iff (!rst_n)
                                   rx_push |-> rx_level < FIFO_DEPTH)
        else begin
            fail_count++;
            $error("push into a full receive FIFO");
        end

endmodule

bind uart_top uart_sva #(.FIFO_DEPTH(FIFO_DEPTH)) i_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done),
    .rx_valid (rx_valid),
    .tx_push  (tx_push),
    .tx_pop   (tx_pop),
    .rx_push  (rx_push),
    .rx_pop   (rx_pop)
);

`default_nettype wire

//--- src/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int CLOCK_HZ   = 50_000_000
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire uart_reg_pkg::bus_req_t bus_req,
    output uart_reg_pkg::reg_data_t     rdata,
    output logic                        tx,
    input  wire logic                   rx,
    output logic                        irq
);

    uart_line_pkg::line_cfg_t   cfg;
    uart_line_pkg::data_byte_t  tx_head;
    uart_line_pkg::data_byte_t  rx_head;
    uart_line_pkg::rx_result_t  rx_result;
    logic                       tx_push;
    logic                       tx_pop;
    logic                       tx_full;
    logic                       tx_empty;
    logic                       tx_busy;
    logic                       tx_done;
    logic                       rx_push;
    logic                       rx_pop;
    logic                       rx_full;
    logic                       rx_empty;
    logic                       rx_valid;

    uart_regs #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CLOCK_HZ   (CLOCK_HZ)
    ) i_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .rdata     (rdata),
        .cfg       (cfg),
        .tx_push   (tx_push),
        .tx_full   (tx_full),
        .rx_pop    (rx_pop),
        .rx_empty  (rx_empty),
        .rx_head   (rx_head),
        .tx_busy   (tx_busy),
        .tx_done   (tx_done),
        .rx_valid  (rx_valid),
        .rx_result (rx_result),
        .rx_push   (rx_push),
        .rx_full   (rx_full),
        .irq       (irq)
    );

    // Transmit bytes come straight from the bus write data.
    byte_fifo #(.DEPTH(FIFO_DEPTH)) i_tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (bus_req.wdata[7:0]),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    byte_fifo #(.DEPTH(FIFO_DEPTH)) i_rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_push),
        .push_data (rx_result.data),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    uart_tx i_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .fifo_empty (tx_empty),
        .fifo_data  (tx_head),
        .fifo_pop   (tx_pop),
        .tx         (tx),
        .busy       (tx_busy),
        .done       (tx_done)
    );

    uart_rx i_rx (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg    (cfg),
        .rx     (rx),
        .valid  (rx_valid),
        .result (rx_result)
    );

endmodule

`default_nettype wire

//--- uart_rx/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire uart_line_pkg::line_cfg_t cfg,
    input  wire logic                     rx,
    output logic                          valid,
    output uart_line_pkg::rx_result_t     result
);

    uart_line_pkg::rx_state_t  state;
    uart_line_pkg::line_cfg_t  fmt;         // Format held for the whole frame.
    uart_line_pkg::baud_div_t  cnt;
    uart_line_pkg::bit_count_t idx;
    uart_line_pkg::data_byte_t data;
    logic                      rx_meta;
    logic                      rx_sync;
    logic                      par_sample;
    logic                      frame_bad;
    logic                      sample_tick;
    logic                      last_sample;

    assign sample_tick = state == uart_line_pkg::RX_SAMPLE && cnt == '0;
    assign last_sample = idx == uart_line_pkg::frame_len(fmt) - 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;   // Idle line level.
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ****************************************
    // Bit timing
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= uart_line_pkg::RX_IDLE;
            valid <= 1'b0;
            cnt   <= '0;
            idx   <= '0;
        end else begin
            valid <= 1'b0;
            if (!cfg.enable) begin
                state <= uart_line_pkg::RX_IDLE;
            end else if (state == uart_line_pkg::RX_IDLE) begin
                if (!rx_sync) begin
                    state <= uart_line_pkg::RX_SAMPLE;
                    cnt   <= cfg.baud_div >> 1;   // First sample lands mid start bit.
                    idx   <= '0;
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else begin
                cnt <= fmt.baud_div;
                idx <= idx + 1'b1;
                if (last_sample) begin
                    state <= uart_line_pkg::RX_IDLE;
                    valid <= 1'b1;
                end
            end
        end
    end

    // ****************************************
    // Sampling and frame check
    // ****************************************
    always_ff @(posedge clk) begin
        if (state == uart_line_pkg::RX_IDLE) begin
            fmt       <= cfg;
            frame_bad <= 1'b0;
        end else if (sample_tick) begin
            if (idx == '0)
                frame_bad <= rx_sync;                   // Start bit must still be low.
            else if (idx <= 4'd8)
                data <= {rx_sync, data[7:1]};           // LSB arrives first.
            else if (fmt.parity_en && idx == 4'd9)
                par_sample <= rx_sync;
            else if (!rx_sync)
                frame_bad <= 1'b1;

            if (last_sample) begin
                result.data       <= data;
                result.frame_err  <= frame_bad || !rx_sync;
                result.parity_err <= fmt.parity_en &&
                    (par_sample != uart_line_pkg::parity_bit(data, fmt.parity_odd));
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_tx/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire uart_line_pkg::line_cfg_t  cfg,
    input  wire logic                      fifo_empty,
    input  wire uart_line_pkg::data_byte_t fifo_data,
    output logic                           fifo_pop,
    output logic                           tx,
    output logic                           busy,
    output logic                           done
);

    localparam int FB = uart_line_pkg::MAX_FRAME_BITS;

    uart_line_pkg::tx_state_t  state;
    uart_line_pkg::frame_t     image;
    uart_line_pkg::frame_t     shift;       // Bits still to go out, next one in bit 0.
    uart_line_pkg::bit_count_t bits_left;
    uart_line_pkg::baud_div_t  baud_cnt;
    logic                      bit_end;

    assign fifo_pop = state == uart_line_pkg::TX_IDLE && cfg.enable && !fifo_empty;
    assign busy     = state == uart_line_pkg::TX_SHIFT;
    assign bit_end  = busy && baud_cnt >= cfg.baud_div;

    // Start bit in bit 0; unused upper bits stay high as stop bits.
    always_comb begin
        image      = '1;
        image[0]   = 1'b0;
        image[8:1] = fifo_data;
        if (cfg.parity_en)
            image[9] = uart_line_pkg::parity_bit(fifo_data, cfg.parity_odd);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= uart_line_pkg::TX_IDLE;
            tx        <= 1'b1;
            done      <= 1'b0;
            bits_left <= '0;
            baud_cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (!cfg.enable) begin
                state <= uart_line_pkg::TX_IDLE;
                tx    <= 1'b1;
            end else if (fifo_pop) begin
                state     <= uart_line_pkg::TX_SHIFT;
                tx        <= image[0];
                bits_left <= uart_line_pkg::frame_len(cfg);
                baud_cnt  <= '0;
            end else if (bit_end) begin
                baud_cnt  <= '0;
                bits_left <= bits_left - 1'b1;
                tx        <= shift[0];
                if (bits_left == 4'd1) begin   // Last stop bit has run its period.
                    state <= uart_line_pkg::TX_IDLE;
                    tx    <= 1'b1;
                    done  <= 1'b1;
                end
            end else if (busy) begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop)
            shift <= {1'b1, image[FB-1:1]};
        else if (bit_end)
            shift <= {1'b1, shift[FB-1:1]};
    end

endmodule

`default_nettype wire

//--- src/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs #(
    parameter int FIFO_DEPTH = 8,
    parameter int CLOCK_HZ   = 50_000_000
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire uart_reg_pkg::bus_req_t    bus_req,
    output uart_reg_pkg::reg_data_t        rdata,
    output uart_line_pkg::line_cfg_t       cfg,
    output logic                           tx_push,
    input  wire logic                      tx_full,
    output logic                           rx_pop,
    input  wire logic                      rx_empty,
    input  wire uart_line_pkg::data_byte_t rx_head,
    input  wire logic                      tx_busy,
    input  wire logic                      tx_done,
    input  wire logic                      rx_valid,
    input  wire uart_line_pkg::rx_result_t rx_result,
    output logic                           rx_push,
    input  wire logic                      rx_full,
    output logic                           irq
);

    localparam uart_line_pkg::baud_div_t BAUD_RESET =
        uart_line_pkg::baud_div_t'(CLOCK_HZ / 115200 - 1);
    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    logic [3:0]               ctrl;
    uart_line_pkg::baud_div_t baud;
    uart_reg_pkg::irq_vec_t   irq_en;
    uart_reg_pkg::irq_vec_t   irq_status;
    logic                     irq_tx_done;
    logic                     irq_err;
    logic                     frame_err;
    logic                     parity_err;
    logic                     overrun;
    logic [LEVEL_W-1:0]       tx_level;    // Bytes in the transmit FIFO not yet started.
    logic                     tx_busy_q;
    logic                     tx_start;
    logic                     wr_irq_status;
    logic                     rx_good;

    assign wr_irq_status = bus_req.write && bus_req.addr == uart_reg_pkg::ADDR_IRQ_STATUS;
    assign tx_push  = bus_req.write && bus_req.addr == uart_reg_pkg::ADDR_DATA && !tx_full;
    assign rx_pop   = bus_req.read && bus_req.addr == uart_reg_pkg::ADDR_DATA && !rx_empty;
    assign rx_good  = rx_valid && !rx_result.frame_err && !rx_result.parity_err;
    assign rx_push  = rx_good && !rx_full;
    assign tx_start = tx_busy && !tx_busy_q;   // A frame leaves the FIFO.

    assign cfg = '{enable:     ctrl[uart_reg_pkg::CTRL_ENABLE],
                   parity_en:  ctrl[uart_reg_pkg::CTRL_PARITY_EN],
                   parity_odd: ctrl[uart_reg_pkg::CTRL_PARITY_ODD],
                   two_stop:   ctrl[uart_reg_pkg::CTRL_TWO_STOP],
                   baud_div:   baud};

    always_comb begin
        irq_status = '0;
        irq_status[uart_reg_pkg::IRQ_RX]      = !rx_empty;
        irq_status[uart_reg_pkg::IRQ_TX_DONE] = irq_tx_done;
        irq_status[uart_reg_pkg::IRQ_ERR]     = irq_err;
    end

    assign irq = |(irq_en & irq_status);

    // ****************************************
    // Control registers
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl   <= 4'b0001;   // Enabled, 8N1.
            baud   <= BAUD_RESET;
            irq_en <= '0;
        end else if (bus_req.write) begin
            case (bus_req.addr)
                uart_reg_pkg::ADDR_CTRL:   ctrl   <= bus_req.wdata[3:0];
                uart_reg_pkg::ADDR_BAUD:   baud   <= bus_req.wdata[15:0];
                uart_reg_pkg::ADDR_IRQ_EN: irq_en <= bus_req.wdata[2:0];
                default: ;
            endcase
        end
    end

    // ****************************************
    // Status and interrupt bits
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_err   <= 1'b0;
            parity_err  <= 1'b0;
            overrun     <= 1'b0;
            irq_err     <= 1'b0;
            irq_tx_done <= 1'b0;
            tx_level    <= '0;
            tx_busy_q   <= 1'b0;
        end else begin
            tx_busy_q <= tx_busy;
            case ({tx_push, tx_start})
                2'b10:   tx_level <= tx_level + 1'b1;
                2'b01:   tx_level <= tx_level - 1'b1;
                default: ;
            endcase

            if (wr_irq_status && bus_req.wdata[uart_reg_pkg::IRQ_ERR]) begin
                frame_err  <= 1'b0;
                parity_err <= 1'b0;
                overrun    <= 1'b0;
                irq_err    <= 1'b0;
            end
            if (rx_valid) begin
                if (rx_result.frame_err)
                    frame_err <= 1'b1;
                if (rx_result.parity_err)
                    parity_err <= 1'b1;
                if (rx_good && rx_full)
                    overrun <= 1'b1;   // The new byte is lost.
                if (!rx_push)
                    irq_err <= 1'b1;
            end

            if (tx_done && tx_level == '0)
                irq_tx_done <= 1'b1;
            if (tx_push || (wr_irq_status && bus_req.wdata[uart_reg_pkg::IRQ_TX_DONE]))
                irq_tx_done <= 1'b0;
        end
    end

    always_comb begin
        rdata = '0;
        if (bus_req.read) begin
            case (bus_req.addr)
                uart_reg_pkg::ADDR_DATA: begin
                    if (!rx_empty)
                        rdata[7:0] = rx_head;
                end
                uart_reg_pkg::ADDR_STATUS: begin
                    rdata[uart_reg_pkg::ST_RX_AVAIL]    = !rx_empty;
                    rdata[uart_reg_pkg::ST_TX_NOT_FULL] = !tx_full;
                    rdata[uart_reg_pkg::ST_FRAME_ERR]   = frame_err;
                    rdata[uart_reg_pkg::ST_OVERRUN]     = overrun;
                    rdata[uart_reg_pkg::ST_TX_BUSY]     = tx_busy;
                    rdata[uart_reg_pkg::ST_PARITY_ERR]  = parity_err;
                end
                uart_reg_pkg::ADDR_CTRL:       rdata[3:0]  = ctrl;
                uart_reg_pkg::ADDR_BAUD:       rdata[15:0] = baud;
                uart_reg_pkg::ADDR_IRQ_EN:     rdata[2:0]  = irq_en;
                uart_reg_pkg::ADDR_IRQ_STATUS: rdata[2:0]  = irq_status;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int DEPTH = 8   // Power of two.
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      push,
    input  wire uart_line_pkg::data_byte_t push_data,
    input  wire logic                      pop,
    output uart_line_pkg::data_byte_t      pop_data,
    output logic                           full,
    output logic                           empty
);

    localparam int AW = $clog2(DEPTH);

    uart_line_pkg::data_byte_t mem [DEPTH];
    logic [AW:0]               wr_ptr;
    logic [AW:0]               rd_ptr;

    // The extra pointer bit tells a full buffer from an empty one.
    assign empty    = wr_ptr == rd_ptr;
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign pop_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (push && !full)
            mem[wr_ptr[AW-1:0]] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- common/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

    localparam int MAX_FRAME_BITS = 12;

    typedef logic [7:0]                data_byte_t;
    typedef logic [15:0]               baud_div_t;   // Clocks per bit minus one.
    typedef logic [MAX_FRAME_BITS-1:0] frame_t;
    typedef logic [3:0]                bit_count_t;

    typedef struct packed {
        logic      enable;
        logic      parity_en;
        logic      parity_odd;
        logic      two_stop;
        baud_div_t baud_div;
    } line_cfg_t;

    typedef struct packed {
        data_byte_t data;
        logic       frame_err;
        logic       parity_err;
    } rx_result_t;

    typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;
    typedef enum logic {RX_IDLE, RX_SAMPLE} rx_state_t;

    // Start, eight data bits and one stop bit, plus the optional bits.
    function automatic bit_count_t frame_len(line_cfg_t cfg);
        return bit_count_t'(10) + bit_count_t'(cfg.parity_en) + bit_count_t'(cfg.two_stop);
    endfunction

    // Even parity makes the total count of ones even.
    function automatic logic parity_bit(data_byte_t data, logic odd);
        return (^data) ^ odd;
    endfunction

endpackage

`default_nettype wire

//--- common/uart_reg_pkg.sv
`default_nettype none

package uart_reg_pkg;

    typedef logic [3:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    typedef struct packed {
        logic      write;   // One-cycle write strobe.
        logic      read;    // Read strobe, rdata is valid while it is high.
        reg_addr_t addr;
        reg_data_t wdata;
    } bus_req_t;

    // ****************************************
    // Register map
    // ****************************************
    localparam reg_addr_t ADDR_DATA       = 4'd0;
    localparam reg_addr_t ADDR_STATUS     = 4'd1;
    localparam reg_addr_t ADDR_CTRL       = 4'd2;
    localparam reg_addr_t ADDR_BAUD       = 4'd3;
    localparam reg_addr_t ADDR_IRQ_EN     = 4'd4;
    localparam reg_addr_t ADDR_IRQ_STATUS = 4'd5;

    localparam int CTRL_ENABLE     = 0;
    localparam int CTRL_PARITY_EN  = 1;
    localparam int CTRL_PARITY_ODD = 2;
    localparam int CTRL_TWO_STOP   = 3;

    localparam int ST_RX_AVAIL    = 0;
    localparam int ST_TX_NOT_FULL = 1;
    localparam int ST_FRAME_ERR   = 2;
    localparam int ST_OVERRUN     = 3;
    localparam int ST_TX_BUSY     = 4;
    localparam int ST_PARITY_ERR  = 5;

    // Interrupt sources, same order in IRQ_EN and IRQ_STATUS.
    typedef logic [2:0] irq_vec_t;

    localparam int IRQ_RX      = 0;
    localparam int IRQ_TX_DONE = 1;
    localparam int IRQ_ERR     = 2;

endpackage

`default_nettype wire
